//--- hdl/game_port_pkg.sv
// Game port package with joystick word widths, pad bit positions and word types

package game_port_pkg;

	// ===================================================================
	// Digital joystick word
	// ===================================================================

	// Bit order is Fire 2, Fire 1, Up, Down, Left, Right
	localparam int JOY_BITS = 6;

	// Fire 1 position; the four direction bits sit below it
	localparam int JOY_FIRE_MERGED = 4;

	// ===================================================================
	// Analog stick word
	// ===================================================================

	localparam int AXIS_W = 8;

	// X axis in the high byte, Y axis in the low byte
	localparam int ANALOG_W = 16;

	// Paddle bit flipped to turn the paddle into a signed axis value
	localparam int PADDLE_SIGN = 7;

	// ===================================================================
	// Decoded DB9 / DB15 pad word
	// ===================================================================

	// Low nibble is Up, Down, Left, Right like the joystick word
	localparam int PAD_W = 16;

	localparam int DB_BTN_A = 4;
	localparam int DB_BTN_B = 5;
	localparam int DB_BTN_C = 6;
	localparam int DB_START = 10;

	// Word types
	typedef logic [JOY_BITS-1:0] joy_word_t;

	typedef logic [AXIS_W-1:0] axis_t;

	typedef logic [ANALOG_W-1:0] analog_word_t;

	typedef logic [PAD_W-1:0] pad_word_t;

endpackage

//--- hdl/joy_digital_select.sv
// Digital joystick select: pad source choice, menu muting and menu request

`timescale 1ns/100ps

module joy_digital_select
	import game_port_pkg::*;
(
	input  logic      clk_sys,
	input  logic      dd_reset,

	// Joystick sources
	input  joy_word_t usb_joy,
	input  pad_word_t pad_db9,
	input  pad_word_t pad_db15,
	input  logic      use_db9,
	input  logic      use_db15,

	// On-screen menu state
	input  logic      osd_open,

	output joy_word_t pad_joy,
	output joy_word_t menu_raw,
	output logic      menu_request
);

	pad_word_t sel_pad;
	logic      pad_ena;
	joy_word_t pad_mapped;
	joy_word_t pad_joy_nxt;
	joy_word_t menu_raw_nxt;
	logic      menu_request_nxt;

	// ===================================================================
	// Source selection
	// ===================================================================

	// DB9 wins over DB15 when both are enabled
	always_comb begin
		if (use_db9) begin
			sel_pad = pad_db9;
		end else if (use_db15) begin
			sel_pad = pad_db15;
		end else begin
			sel_pad = '0;
		end
	end

	assign pad_ena = use_db9 | use_db15;

	// C becomes Fire 2, A and B share Fire 1
	assign pad_mapped = {
		sel_pad[DB_BTN_C],
		sel_pad[DB_BTN_B] | sel_pad[DB_BTN_A],
		sel_pad[JOY_FIRE_MERGED-1:0]
	};

	// ===================================================================
	// Menu muting and menu request
	// ===================================================================

	always_comb begin
		if (!pad_ena) begin
			pad_joy_nxt = usb_joy;
		end else if (osd_open) begin
			// External pad drives the menu instead of the game
			pad_joy_nxt = '0;
		end else begin
			pad_joy_nxt = pad_mapped;
		end
	end

	// Raw direction and button bits for menu navigation
	assign menu_raw_nxt = osd_open ? sel_pad[JOY_BITS-1:0] : '0;

	// Start plus C opens the menu
	assign menu_request_nxt = sel_pad[DB_START] & sel_pad[DB_BTN_C];

	// ===================================================================
	// Output registers
	// ===================================================================

	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			pad_joy      <= '0;
			menu_raw     <= '0;
			menu_request <= 1'b0;
		end else begin
			pad_joy      <= pad_joy_nxt;
			menu_raw     <= menu_raw_nxt;
			menu_request <= menu_request_nxt;
		end
	end

endmodule

//--- hdl/joy_analog_select.sv
// Analog stick select: axis swap, paddle substitution and zero-axis flags

`timescale 1ns/100ps

module joy_analog_select
	import game_port_pkg::*;
(
	input  logic         clk_sys,
	input  logic         dd_reset,

	// Analog sources
	input  analog_word_t analog_in,
	input  axis_t        paddle_in,

	// Axis options
	input  logic         axes_swapped,
	input  logic         paddle_on_x,
	input  logic         paddle_on_y,

	output analog_word_t stick_an,
	output logic         x_zero,
	output logic         y_zero
);

	analog_word_t stick_word;
	axis_t        stick_x;
	axis_t        stick_y;
	axis_t        paddle_val;
	axis_t        an_x_nxt;
	axis_t        an_y_nxt;

	// ===================================================================
	// Axis order
	// ===================================================================

	// Host word arrives with the axes in the opposite order by default
	always_comb begin
		if (axes_swapped) begin
			stick_word = analog_in;
		end else begin
			stick_word = {analog_in[AXIS_W-1:0], analog_in[ANALOG_W-1:AXIS_W]};
		end
	end

	assign stick_x = stick_word[ANALOG_W-1:AXIS_W];
	assign stick_y = stick_word[AXIS_W-1:0];

	// ===================================================================
	// Paddle substitution
	// ===================================================================

	// Unsigned paddle position to signed axis value
	always_comb begin
		paddle_val              = paddle_in;
		paddle_val[PADDLE_SIGN] = ~paddle_in[PADDLE_SIGN];
	end

	always_comb begin
		an_x_nxt = stick_x;
		an_y_nxt = stick_y;
		if (paddle_on_x) begin
			an_x_nxt = paddle_val;
		end
		if (paddle_on_y) begin
			an_y_nxt = paddle_val;
		end
	end

	// ===================================================================
	// Output registers
	// ===================================================================

	// Zero flags look at the stick itself and ignore the paddle
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			stick_an <= '0;
			x_zero   <= 1'b0;
			y_zero   <= 1'b0;
		end else begin
			stick_an <= {an_x_nxt, an_y_nxt};
			x_zero   <= (stick_x == '0);
			y_zero   <= (stick_y == '0);
		end
	end

endmodule

//--- hdl/game_port_merge.sv
// Game port merge: masks digital directions by analog deflection, registers both words

`timescale 1ns/100ps

module game_port_merge
	import game_port_pkg::*;
(
	input  logic         clk_sys,
	input  logic         dd_reset,

	// Digital path
	input  joy_word_t    pad_joy,

	// Analog path
	input  analog_word_t stick_an,
	input  logic         x_zero,
	input  logic         y_zero,

	output joy_word_t    joy,
	output analog_word_t joy_an
);

	joy_word_t dir_mask;
	joy_word_t joy_nxt;

	// ===================================================================
	// Direction mask
	// ===================================================================

	// Fire bits always pass
	// Up/Down follow the Y axis, Left/Right follow the X axis
	always_comb begin
		dir_mask                         = '1;
		dir_mask[JOY_FIRE_MERGED-1 -: 2] = {2{y_zero}};
		dir_mask[1:0]                    = {2{x_zero}};
	end

	assign joy_nxt = pad_joy & dir_mask;

	// ===================================================================
	// Output registers
	// ===================================================================

	// Both words leave together so the core sees a matched pair
	always_ff @(posedge clk_sys) begin
		if (dd_reset) begin
			joy    <= '0;
			joy_an <= '0;
		end else begin
			joy    <= joy_nxt;
			joy_an <= stick_an;
		end
	end

endmodule

//--- hdl/game_port_top.sv
// Game port top: digital and analog joystick conditioning feeding the merge stage

`timescale 1ns/100ps

module game_port_top
	import game_port_pkg::*;
(
	input  logic         clk_sys,
	input  logic         dd_reset,

	// Digital sources
	input  joy_word_t    usb_joy,
	input  pad_word_t    pad_db9,
	input  pad_word_t    pad_db15,
	input  logic         use_db9,
	input  logic         use_db15,
	input  logic         osd_open,

	// Analog sources
	input  analog_word_t analog_in,
	input  axis_t        paddle_in,
	input  logic         axes_swapped,
	input  logic         paddle_on_x,
	input  logic         paddle_on_y,

	// To the core, two clocks after the inputs
	output joy_word_t    joy,
	output analog_word_t joy_an,

	// To the menu, one clock after the inputs
	output joy_word_t    menu_raw,
	output logic         menu_request
);

	joy_word_t    pad_joy;
	analog_word_t stick_an;
	logic         x_zero;
	logic         y_zero;

	joy_digital_select u_digital (
		.clk_sys      (clk_sys),
		.dd_reset     (dd_reset),
		.usb_joy      (usb_joy),
		.pad_db9      (pad_db9),
		.pad_db15     (pad_db15),
		.use_db9      (use_db9),
		.use_db15     (use_db15),
		.osd_open     (osd_open),
		.pad_joy      (pad_joy),
		.menu_raw     (menu_raw),
		.menu_request (menu_request)
	);

	joy_analog_select u_analog (
		.clk_sys      (clk_sys),
		.dd_reset     (dd_reset),
		.analog_in    (analog_in),
		.paddle_in    (paddle_in),
		.axes_swapped (axes_swapped),
		.paddle_on_x  (paddle_on_x),
		.paddle_on_y  (paddle_on_y),
		.stick_an     (stick_an),
		.x_zero       (x_zero),
		.y_zero       (y_zero)
	);

	game_port_merge u_merge (
		.clk_sys  (clk_sys),
		.dd_reset (dd_reset),
		.pad_joy  (pad_joy),
		.stick_an (stick_an),
		.x_zero   (x_zero),
		.y_zero   (y_zero),
		.joy      (joy),
		.joy_an   (joy_an)
	);

endmodule

//--- tests/game_port_checker.sv
// Game port merge checker for direction masking and analog output timing

`timescale 1ns/100ps

module game_port_checker
	import game_port_pkg::*;
(
	input  logic         clk_sys,
	input  logic         dd_reset,
	input  analog_word_t stick_an,
	input  logic         x_zero,
	input  logic         y_zero,
	input  joy_word_t    joy,
	input  analog_word_t joy_an
);

	// Count of failed assertions
	int assert_fails = 0;

	// ===================================================================
	// Direction masking
	// ===================================================================

	a_y_mask: assert property (@(posedge clk_sys) disable iff (dd_reset)
		!y_zero |=> (joy[JOY_FIRE_MERGED-1 -: 2] == 2'b00))
		else begin
			$error("Up and Down still set after the Y axis was deflected");
			assert_fails++;
		end

	a_x_mask: assert property (@(posedge clk_sys) disable iff (dd_reset)
		!x_zero |=> (joy[1:0] == 2'b00))
		else begin
			$error("Left and Right still set after the X axis was deflected");
			assert_fails++;
		end

	// ===================================================================
	// Analog word timing
	// ===================================================================

	a_an_follow: assert property (@(posedge clk_sys) disable iff (dd_reset)
		1'b1 |=> (joy_an == $past(stick_an)))
		else begin
			$error("joy_an does not equal stick_an of the previous cycle");
			assert_fails++;
		end

endmodule

bind game_port_merge game_port_checker u_checker (
	.clk_sys  (clk_sys),
	.dd_reset (dd_reset),
	.stick_an (stick_an),
	.x_zero   (x_zero),
	.y_zero   (y_zero),
	.joy      (joy),
	.joy_an   (joy_an)
);

//--- tests/game_port_monitor.sv
// Game port monitor: reference model, latency-aligned comparison and per-test results

`timescale 1ns/100ps

module game_port_monitor
	import game_port_pkg::*;
(
	input  logic         clk_sys,
	input  logic         dd_reset,
	input  joy_word_t    usb_joy,
	input  pad_word_t    pad_db9,
	input  pad_word_t    pad_db15,
	input  logic         use_db9,
	input  logic         use_db15,
	input  logic         osd_open,
	input  analog_word_t analog_in,
	input  axis_t        paddle_in,
	input  logic         axes_swapped,
	input  logic         paddle_on_x,
	input  logic         paddle_on_y,
	input  joy_word_t    joy,
	input  analog_word_t joy_an,
	input  joy_word_t    menu_raw,
	input  logic         menu_request,

	// Test sequencing
	input  int           test_id,
	input  logic         end_req,
	output logic         end_done,
	output int           tests_run,
	output int           tests_failed,
	output int           mismatches
);

	pad_word_t    in_pad;
	axis_t        in_x;
	axis_t        in_y;
	joy_word_t    exp_joy_d1;
	joy_word_t    exp_joy_d2;
	analog_word_t exp_an_d1;
	analog_word_t exp_an_d2;
	joy_word_t    exp_menu_raw_d1;
	logic         exp_menu_req_d1;
	logic         primed = 1'b0;
	logic         done_q = 1'b0;
	int           cur_id = 0;
	int           checks_total = 0;
	int           err_total = 0;
	int           checks_at_start = 0;
	int           err_at_start = 0;
	int           run_cnt = 0;
	int           fail_cnt = 0;

	assign end_done     = done_q;
	assign tests_run    = run_cnt;
	assign tests_failed = fail_cnt;
	assign mismatches   = err_total;

	function automatic string test_label(input int id);
		case (id)
			0:       return "reset";
			1:       return "source_select";
			2:       return "menu_mute";
			3:       return "analog_path";
			4:       return "direction_mask";
			5:       return "back_to_back";
			default: return "unknown";
		endcase
	endfunction

	// ===================================================================
	// Reference model
	// ===================================================================

	assign in_pad = use_db9 ? pad_db9 : (use_db15 ? pad_db15 : '0);
	assign in_x   = axes_swapped ? analog_in[ANALOG_W-1:AXIS_W] : analog_in[AXIS_W-1:0];
	assign in_y   = axes_swapped ? analog_in[AXIS_W-1:0] : analog_in[ANALOG_W-1:AXIS_W];

	function automatic joy_word_t expect_joy(input joy_word_t usb, input pad_word_t pad,
		input logic ena, input logic osd, input axis_t sx, input axis_t sy);
		joy_word_t word;
		if (!ena) begin
			word = usb;
		end else if (osd) begin
			word = '0;
		end else begin
			word[5]   = pad[DB_BTN_C];
			word[4]   = pad[DB_BTN_A] | pad[DB_BTN_B];
			word[3:0] = pad[3:0];
		end
		// A deflected axis cancels its pair of directions
		if (sy != '0) begin
			word[3:2] = 2'b00;
		end
		if (sx != '0) begin
			word[1:0] = 2'b00;
		end
		return word;
	endfunction

	function automatic analog_word_t expect_an(input axis_t sx, input axis_t sy,
		input axis_t paddle, input logic on_x, input logic on_y);
		axis_t pv;
		pv = paddle ^ (axis_t'(1) << PADDLE_SIGN);
		return {on_x ? pv : sx, on_y ? pv : sy};
	endfunction

	always @(posedge clk_sys) begin
		primed <= 1'b1;
		cur_id <= test_id;
		if (dd_reset) begin
			exp_joy_d1      <= '0;
			exp_joy_d2      <= '0;
			exp_an_d1       <= '0;
			exp_an_d2       <= '0;
			exp_menu_raw_d1 <= '0;
			exp_menu_req_d1 <= 1'b0;
		end else begin
			exp_joy_d1      <= expect_joy(usb_joy, in_pad, use_db9 | use_db15, osd_open,
				in_x, in_y);
			exp_joy_d2      <= exp_joy_d1;
			exp_an_d1       <= expect_an(in_x, in_y, paddle_in, paddle_on_x, paddle_on_y);
			exp_an_d2       <= exp_an_d1;
			exp_menu_raw_d1 <= osd_open ? in_pad[JOY_BITS-1:0] : '0;
			exp_menu_req_d1 <= in_pad[DB_START] & in_pad[DB_BTN_C];
		end
	end

	// ===================================================================
	// Comparison on the falling edge, where the outputs are stable
	// ===================================================================

	task automatic compare_field(input string field, input logic [15:0] expected,
		input logic [15:0] actual);
		checks_total = checks_total + 1;
		if (actual !== expected) begin
			err_total = err_total + 1;
			$display("error %0s: %0s expected %h actual %h", test_label(cur_id), field,
				expected, actual);
		end
	endtask

	always @(negedge clk_sys) begin
		if (primed) begin
			compare_field("joy", 16'(exp_joy_d2), 16'(joy));
			compare_field("joy_an", exp_an_d2, joy_an);
			compare_field("menu_raw", 16'(exp_menu_raw_d1), 16'(menu_raw));
			compare_field("menu_request", 16'(exp_menu_req_d1), 16'(menu_request));
		end
	end

	// End of test handshake with one result line per test
	always @(posedge clk_sys) begin
		if (end_req && !done_q) begin : close_test
			int n_chk;
			int n_err;
			n_chk = checks_total - checks_at_start;
			n_err = err_total - err_at_start;
			if (n_err == 0) begin
				$display("test %0s: pass, %0d checks", test_label(cur_id), n_chk);
			end else begin
				$display("test %0s: fail, %0d of %0d checks wrong", test_label(cur_id),
					n_err, n_chk);
				fail_cnt <= fail_cnt + 1;
			end
			run_cnt         <= run_cnt + 1;
			checks_at_start <= checks_total;
			err_at_start    <= err_total;
			done_q          <= 1'b1;
		end else if (!end_req) begin
			done_q <= 1'b0;
		end
	end

endmodule

//--- tests/tb_game_port.sv
// Game port testbench with clock, reset, seeded random stimulus and test sequencing

`timescale 1ns/100ps

module tb_game_port
	import game_port_pkg::*;
();

	logic         clk_sys = 1'b0;
	logic         dd_reset;
	joy_word_t    usb_joy;
	pad_word_t    pad_db9;
	pad_word_t    pad_db15;
	logic         use_db9;
	logic         use_db15;
	logic         osd_open;
	analog_word_t analog_in;
	axis_t        paddle_in;
	logic         axes_swapped;
	logic         paddle_on_x;
	logic         paddle_on_y;
	joy_word_t    joy;
	analog_word_t joy_an;
	joy_word_t    menu_raw;
	logic         menu_request;

	int           test_id;
	logic         end_req;
	logic         end_done;
	int           tests_run;
	int           tests_failed;
	int           mismatches;
	logic         hung;

	always #50 clk_sys = ~clk_sys;

	game_port_top uut (.*);

	game_port_monitor u_monitor (.*);

	// ===================================================================
	// Stimulus
	// ===================================================================

	// Test id picks which inputs are held fixed
	task automatic drive_random(input int id);
		usb_joy      = joy_word_t'($urandom());
		pad_db9      = pad_word_t'($urandom());
		pad_db15     = pad_word_t'($urandom());
		use_db9      = 1'($urandom());
		use_db15     = 1'($urandom());
		osd_open     = ($urandom_range(0, 3) == 0);
		analog_in    = analog_word_t'($urandom());
		paddle_in    = axis_t'($urandom());
		axes_swapped = 1'($urandom());
		paddle_on_x  = 1'($urandom());
		paddle_on_y  = 1'($urandom());
		case (id)
			// Source selection with the stick centred
			1: begin
				osd_open    = 1'b0;
				analog_in   = '0;
				paddle_on_x = 1'b0;
				paddle_on_y = 1'b0;
			end
			// Menu open with an external pad enabled
			2: begin
				osd_open  = 1'b1;
				analog_in = '0;
				if (!use_db9 && !use_db15) begin
					use_db15 = 1'b1;
				end
				if ($urandom_range(0, 1) == 0) begin
					pad_db9[DB_START]  = 1'b1;
					pad_db9[DB_BTN_C]  = 1'b1;
					pad_db15[DB_START] = 1'b1;
					pad_db15[DB_BTN_C] = 1'b1;
				end
			end
			3: osd_open = 1'b0;
			// Centred axes are common so both mask states show up
			4, 5: begin
				if (id == 4) begin
					osd_open = 1'b0;
				end
				if ($urandom_range(0, 1) == 0) begin
					analog_in[ANALOG_W-1:AXIS_W] = '0;
				end
				if ($urandom_range(0, 1) == 0) begin
					analog_in[AXIS_W-1:0] = '0;
				end
			end
			default: ;
		endcase
	endtask

	task automatic finish_test();
		int wait_cnt;
		end_req  = 1'b1;
		wait_cnt = 0;
		while (!end_done && wait_cnt < 20) begin
			@(negedge clk_sys);
			wait_cnt++;
		end
		if (!end_done) begin
			$display("monitor did not close test %0d within 20 cycles", test_id);
			hung = 1'b1;
		end
		end_req  = 1'b0;
		wait_cnt = 0;
		while (end_done && wait_cnt < 20) begin
			@(negedge clk_sys);
			wait_cnt++;
		end
		if (end_done) begin
			$display("monitor did not release the end of test %0d", test_id);
			hung = 1'b1;
		end
	endtask

	task automatic run_test(input int id, input int cycles);
		int n;
		test_id = id;
		for (n = 0; n < cycles; n++) begin
			drive_random(id);
			@(negedge clk_sys);
		end
		// Two clocks for the last input set to reach joy and joy_an
		repeat (2) @(negedge clk_sys);
		finish_test();
	endtask

	// ===================================================================
	// Test sequence
	// ===================================================================

	initial begin
		int t;
		void'($urandom(76));
		hung         = 1'b0;
		end_req      = 1'b0;
		test_id      = 0;
		dd_reset     = 1'b1;
		usb_joy      = '0;
		pad_db9      = '0;
		pad_db15     = '0;
		use_db9      = 1'b0;
		use_db15     = 1'b0;
		osd_open     = 1'b0;
		analog_in    = '0;
		paddle_in    = '0;
		axes_swapped = 1'b0;
		paddle_on_x  = 1'b0;
		paddle_on_y  = 1'b0;

		// Inputs keep moving while reset is held
		repeat (4) begin
			@(negedge clk_sys);
			drive_random(0);
		end
		dd_reset = 1'b0;
		run_test(0, 2);

		for (t = 1; t < 6 && !hung; t++) begin
			run_test(t, (t == 5) ? 500 : 60);
		end

		$display("tests run %0d, tests failed %0d, mismatches %0d, assertion failures %0d",
			tests_run, tests_failed, mismatches, uut.u_merge.u_checker.assert_fails);
		if (hung || tests_failed != 0 || mismatches != 0 ||
			uut.u_merge.u_checker.assert_fails != 0) begin
			$display("Errors found");
		end else begin
			$display("No errors");
		end
		$finish;
	end

endmodule

//--- src.f
hdl/game_port_pkg.sv
hdl/joy_digital_select.sv
hdl/joy_analog_select.sv
hdl/game_port_merge.sv
hdl/game_port_top.sv
tests/game_port_checker.sv
tests/game_port_monitor.sv
tests/tb_game_port.sv

//--- Makefile
# Verilator flow for the game port input conditioning

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module tb_game_port

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_game_port -o sim_game_port
	./obj_dir/sim_game_port > sim.log 2>&1 || true
	cat sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
